// File: hdl/ip_mux_defines.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IP frame multiplexer build constants
// source count and payload widths shared by the whole design
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef IP_MUX_DEFINES_SVH
`define IP_MUX_DEFINES_SVH

// number of frame sources feeding the mux
`define IP_MUX_S_COUNT 4

// payload word width, one byte so no tkeep is carried
`define IP_MUX_DATA_WIDTH 8

// sideband width on the payload stream
`define IP_MUX_USER_WIDTH 1

`endif

// File: hdl/ip_mux_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IP frame multiplexer types
// header struct, frame tracker state and payload word types
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "ip_mux_defines.svh"

package ip_mux_pkg;

    // index of one frame source
    typedef logic [$clog2(`IP_MUX_S_COUNT)-1:0] port_sel_t;

    // payload word and its sideband
    typedef logic [`IP_MUX_DATA_WIDTH-1:0] data_t;
    typedef logic [`IP_MUX_USER_WIDTH-1:0] user_t;

    // header fields carried through the mux, 96 bits
    typedef struct packed {
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    // frame tracker, idle until a header is taken
    typedef enum logic {
        FRAME_IDLE   = 1'b0,
        FRAME_ACTIVE = 1'b1
    } frame_state_e;

endpackage

// File: hdl/ip_payload_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IP payload stream
// byte stream from the source mux into the output skid buffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

interface ip_payload_if;

    ip_mux_pkg::data_t tdata;
    logic              tvalid;
    // early ready, valid for the word offered next cycle
    logic              tready;
    logic              tlast;
    ip_mux_pkg::user_t tuser;

    modport src (
        output tdata, tvalid, tlast, tuser,
        input  tready
    );

    modport snk (
        input  tdata, tvalid, tlast, tuser,
        output tready
    );

endinterface

// File: hdl/ip_frame_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IP mux frame control
// picks a source at frame start, registers its header and holds the
// choice until the payload tlast beat has been accepted
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "ip_mux_defines.svh"

module ip_frame_ctrl (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      enable,
    input  ip_mux_pkg::port_sel_t                     select,
    input  logic [`IP_MUX_S_COUNT-1:0]                s_hdr_valid,
    output logic [`IP_MUX_S_COUNT-1:0]                s_hdr_ready,
    input  ip_mux_pkg::ip_hdr_t [`IP_MUX_S_COUNT-1:0] s_hdr,
    output logic                                      m_hdr_valid,
    input  logic                                      m_hdr_ready,
    output ip_mux_pkg::ip_hdr_t                       m_hdr,
    input  logic                                      frame_done,
    output logic                                      route_active,
    output ip_mux_pkg::port_sel_t                     route_port
);

    import ip_mux_pkg::*;

    frame_state_e                state;
    frame_state_e                state_next;
    port_sel_t                   port_q;
    logic                        frame_start;
    logic [`IP_MUX_S_COUNT-1:0]  hdr_ready_next;

    // a new frame only starts once the previous header has left
    assign frame_start = (state == FRAME_IDLE) && enable && !m_hdr_valid
                         && s_hdr_valid[select];

    always_comb begin
        state_next = state;
        case (state)
            FRAME_IDLE: begin
                if (frame_start) begin
                    state_next = FRAME_ACTIVE;
                end
            end
            FRAME_ACTIVE: begin
                if (frame_done) begin
                    state_next = FRAME_IDLE;
                end
            end
            default: state_next = FRAME_IDLE;
        endcase
    end

    always_comb begin
        hdr_ready_next = '0;
        if (frame_start) begin
            hdr_ready_next[select] = 1'b1;
        end
    end

    // route for the payload mux one cycle ahead of the tracker
    assign route_active = (state_next == FRAME_ACTIVE);
    assign route_port   = frame_start ? select : port_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= FRAME_IDLE;
            port_q      <= '0;
            s_hdr_ready <= '0;
            m_hdr_valid <= 1'b0;
        end else begin
            state       <= state_next;
            port_q      <= route_port;
            s_hdr_ready <= hdr_ready_next;
            m_hdr_valid <= frame_start || (m_hdr_valid && !m_hdr_ready);
        end
    end

    // header payload register
    always_ff @(posedge clk) begin
        if (frame_start) begin
            m_hdr <= s_hdr[select];
        end
    end

    // the end of a frame can only come while a frame is open
    a_done_in_frame: assert property (
        @(posedge clk) disable iff (rst) frame_done |-> state == FRAME_ACTIVE
    );

    // held header must not change under output back-pressure
    a_hdr_stable: assert property (
        @(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> $stable(m_hdr)
    );

endmodule

// File: hdl/ip_payload_mux.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IP payload source mux
// registers the per-source ready and routes the selected payload
// stream onto the internal stream toward the skid buffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "ip_mux_defines.svh"

module ip_payload_mux (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    route_active,
    input  ip_mux_pkg::port_sel_t                   route_port,
    input  ip_mux_pkg::data_t [`IP_MUX_S_COUNT-1:0] s_payload_tdata,
    input  logic [`IP_MUX_S_COUNT-1:0]              s_payload_tvalid,
    output logic [`IP_MUX_S_COUNT-1:0]              s_payload_tready,
    input  logic [`IP_MUX_S_COUNT-1:0]              s_payload_tlast,
    input  ip_mux_pkg::user_t [`IP_MUX_S_COUNT-1:0] s_payload_tuser,
    output logic                                    frame_done,
    ip_payload_if.src                               out
);

    import ip_mux_pkg::*;

    port_sel_t                  port_q;
    logic [`IP_MUX_S_COUNT-1:0] tready_next;
    logic                       cur_accept;

    // only the routed source sees ready, and only when the sink has room
    always_comb begin
        tready_next = '0;
        tready_next[route_port] = route_active && out.tready;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            port_q           <= '0;
            s_payload_tready <= '0;
        end else begin
            port_q           <= route_port;
            s_payload_tready <= tready_next;
        end
    end

    // a beat is accepted when the selected source is valid and sees ready
    assign cur_accept = s_payload_tvalid[port_q] && s_payload_tready[port_q];

    assign out.tdata  = s_payload_tdata[port_q];
    assign out.tvalid = cur_accept;
    assign out.tlast  = s_payload_tlast[port_q];
    assign out.tuser  = s_payload_tuser[port_q];

    // end of frame seen by the tracker
    assign frame_done = cur_accept && s_payload_tlast[port_q];

    // no source keeps its ready past the tlast beat
    a_ready_drop_after_last: assert property (
        @(posedge clk) disable iff (rst) frame_done |=> s_payload_tready == '0
    );

endmodule

// File: hdl/ip_payload_skid.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IP payload skid buffer
// output register plus one spare word, so the upstream ready can be
// registered without losing a beat under back-pressure
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module ip_payload_skid (
    input  logic              clk,
    input  logic              rst,
    output ip_mux_pkg::data_t m_payload_tdata,
    output logic              m_payload_tvalid,
    input  logic              m_payload_tready,
    output logic              m_payload_tlast,
    output ip_mux_pkg::user_t m_payload_tuser,
    ip_payload_if.snk         in
);

    import ip_mux_pkg::*;

    // spare word, used only while the output is stalled
    data_t temp_tdata;
    logic  temp_tvalid;
    logic  temp_tlast;
    user_t temp_tuser;

    logic  out_tvalid_next;
    logic  temp_tvalid_next;
    logic  store_in_to_out;
    logic  store_in_to_temp;
    logic  store_temp_to_out;

    // room next cycle unless the spare fills or is already full
    assign in.tready = m_payload_tready
                       || (!temp_tvalid && (!m_payload_tvalid || !in.tvalid));

    always_comb begin
        out_tvalid_next   = m_payload_tvalid;
        temp_tvalid_next  = temp_tvalid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (m_payload_tready || !m_payload_tvalid) begin
            if (temp_tvalid) begin
                // drain the spare word first
                out_tvalid_next   = 1'b1;
                temp_tvalid_next  = 1'b0;
                store_temp_to_out = 1'b1;
            end else begin
                out_tvalid_next = in.tvalid;
                store_in_to_out = 1'b1;
            end
        end else if (in.tvalid) begin
            // output stalled, park the incoming word
            temp_tvalid_next = 1'b1;
            store_in_to_temp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_payload_tvalid <= 1'b0;
            temp_tvalid      <= 1'b0;
        end else begin
            m_payload_tvalid <= out_tvalid_next;
            temp_tvalid      <= temp_tvalid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            m_payload_tdata <= in.tdata;
            m_payload_tlast <= in.tlast;
            m_payload_tuser <= in.tuser;
        end else if (store_temp_to_out) begin
            m_payload_tdata <= temp_tdata;
            m_payload_tlast <= temp_tlast;
            m_payload_tuser <= temp_tuser;
        end
        if (store_in_to_temp) begin
            temp_tdata <= in.tdata;
            temp_tlast <= in.tlast;
            temp_tuser <= in.tuser;
        end
    end

    // upstream ready lags by a cycle, the spare must absorb exactly that beat
    a_temp_no_overwrite: assert property (
        @(posedge clk) disable iff (rst) store_in_to_temp |-> !temp_tvalid
    );

endmodule

// File: hdl/ip_mux.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IP frame multiplexer
// forwards one whole frame, header and payload, from one of several
// sources to a single output
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "ip_mux_defines.svh"

module ip_mux (
    input  logic                                      clk,
    input  logic                                      rst,

    // frame sources
    input  logic [`IP_MUX_S_COUNT-1:0]                s_hdr_valid,
    output logic [`IP_MUX_S_COUNT-1:0]                s_hdr_ready,
    input  ip_mux_pkg::ip_hdr_t [`IP_MUX_S_COUNT-1:0] s_hdr,
    input  ip_mux_pkg::data_t [`IP_MUX_S_COUNT-1:0]   s_payload_tdata,
    input  logic [`IP_MUX_S_COUNT-1:0]                s_payload_tvalid,
    output logic [`IP_MUX_S_COUNT-1:0]                s_payload_tready,
    input  logic [`IP_MUX_S_COUNT-1:0]                s_payload_tlast,
    input  ip_mux_pkg::user_t [`IP_MUX_S_COUNT-1:0]   s_payload_tuser,

    // frame output
    output logic                                      m_hdr_valid,
    input  logic                                      m_hdr_ready,
    output ip_mux_pkg::ip_hdr_t                       m_hdr,
    output ip_mux_pkg::data_t                         m_payload_tdata,
    output logic                                      m_payload_tvalid,
    input  logic                                      m_payload_tready,
    output logic                                      m_payload_tlast,
    output ip_mux_pkg::user_t                         m_payload_tuser,

    // source choice, sampled at frame start
    input  logic                                      enable,
    input  ip_mux_pkg::port_sel_t                     select
);

    import ip_mux_pkg::*;

    logic      route_active;
    port_sel_t route_port;
    logic      frame_done;

    ip_payload_if payload_if ();

    ip_frame_ctrl frame_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .select       (select),
        .s_hdr_valid  (s_hdr_valid),
        .s_hdr_ready  (s_hdr_ready),
        .s_hdr        (s_hdr),
        .m_hdr_valid  (m_hdr_valid),
        .m_hdr_ready  (m_hdr_ready),
        .m_hdr        (m_hdr),
        .frame_done   (frame_done),
        .route_active (route_active),
        .route_port   (route_port)
    );

    ip_payload_mux payload_mux_i (
        .clk              (clk),
        .rst              (rst),
        .route_active     (route_active),
        .route_port       (route_port),
        .s_payload_tdata  (s_payload_tdata),
        .s_payload_tvalid (s_payload_tvalid),
        .s_payload_tready (s_payload_tready),
        .s_payload_tlast  (s_payload_tlast),
        .s_payload_tuser  (s_payload_tuser),
        .frame_done       (frame_done),
        .out              (payload_if.src)
    );

    ip_payload_skid payload_skid_i (
        .clk              (clk),
        .rst              (rst),
        .m_payload_tdata  (m_payload_tdata),
        .m_payload_tvalid (m_payload_tvalid),
        .m_payload_tready (m_payload_tready),
        .m_payload_tlast  (m_payload_tlast),
        .m_payload_tuser  (m_payload_tuser),
        .in               (payload_if.snk)
    );

endmodule

// File: tb/tb_ip_mux.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IP frame multiplexer testbench
// directed frames on every source checked against expected queues
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "ip_mux_defines.svh"

module tb_ip_mux;

    import ip_mux_pkg::*;

    typedef struct packed {
        data_t data;
        logic  last;
        user_t user;
    } beat_t;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          enable;
    port_sel_t                     select;
    logic [`IP_MUX_S_COUNT-1:0]    s_hdr_valid;
    logic [`IP_MUX_S_COUNT-1:0]    s_hdr_ready;
    ip_hdr_t [`IP_MUX_S_COUNT-1:0] s_hdr;
    data_t [`IP_MUX_S_COUNT-1:0]   s_payload_tdata;
    logic [`IP_MUX_S_COUNT-1:0]    s_payload_tvalid;
    logic [`IP_MUX_S_COUNT-1:0]    s_payload_tready;
    logic [`IP_MUX_S_COUNT-1:0]    s_payload_tlast;
    user_t [`IP_MUX_S_COUNT-1:0]   s_payload_tuser;
    logic                          m_hdr_valid;
    logic                          m_hdr_ready;
    ip_hdr_t                       m_hdr;
    data_t                         m_payload_tdata;
    logic                          m_payload_tvalid;
    logic                          m_payload_tready;
    logic                          m_payload_tlast;
    user_t                         m_payload_tuser;

    logic [31:0] lfsr_state = 32'h2f6507b6;
    // beats still to be offered by each source, and beats due at the output
    beat_t       src_q [`IP_MUX_S_COUNT][$];
    beat_t       exp_beat_q [$];
    ip_hdr_t     exp_hdr_q [$];
    logic        rand_ready;
    logic        no_hdr_accept;
    logic        no_hdr_out;
    logic        hdr_held;
    ip_hdr_t     hdr_prev;
    // port whose header was taken last
    int          cur_port;

    ip_mux ip_mux_i (.*);

    always #10 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // taps 32, 22, 2, 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_bit()};
        end
        return r;
    endfunction

    task automatic check_hdr(input string name, input ip_hdr_t got, input ip_hdr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_beat(input data_t got_data, input logic got_last,
                              input user_t got_user, input beat_t exp);
        if (got_data !== exp.data || got_last !== exp.last || got_user !== exp.user) begin
            fail_run($sformatf(
                "mismatch at %0t: m_payload data/last/user got %h/%b/%h expected %h/%b/%h",
                $time, got_data, got_last, got_user, exp.data, exp.last, exp.user));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_ports(input string name, input logic [`IP_MUX_S_COUNT-1:0] got,
                               input logic [`IP_MUX_S_COUNT-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // offer the head of a source queue, or drop valid when it is empty
    task automatic present_beat(input port_sel_t port);
        beat_t b;
        if (src_q[port].size() != 0) begin
            b = src_q[port][0];
            s_payload_tdata[port]  <= b.data;
            s_payload_tlast[port]  <= b.last;
            s_payload_tuser[port]  <= b.user;
            s_payload_tvalid[port] <= 1'b1;
        end else begin
            s_payload_tvalid[port] <= 1'b0;
        end
    endtask

    task automatic load_frame(input port_sel_t port, input int len);
        ip_hdr_t     hdr;
        beat_t       b;
        logic [31:0] r;
        hdr = {random_bits(32), random_bits(32), random_bits(32)};
        for (int i = 0; i < len; i++) begin
            r = random_bits(9);
            b.data = r[7:0];
            b.user = r[8];
            b.last = (i == len - 1);
            src_q[port].push_back(b);
            exp_beat_q.push_back(b);
        end
        exp_hdr_q.push_back(hdr);
        s_hdr[port]       <= hdr;
        s_hdr_valid[port] <= 1'b1;
        present_beat(port);
    endtask

    // one clock cycle that samples at the falling edge and drives at the rising edge
    task automatic step();
        logic [`IP_MUX_S_COUNT-1:0] hdr_take;
        logic [`IP_MUX_S_COUNT-1:0] beat_take;
        port_sel_t                  ps;
        beat_t                      b;
        @(negedge clk);
        hdr_take  = s_hdr_valid & s_hdr_ready;
        beat_take = s_payload_tvalid & s_payload_tready;
        for (int p = 0; p < `IP_MUX_S_COUNT; p++) begin
            ps = port_sel_t'(p);
            if (hdr_take[ps]) begin
                cur_port = p;
            end
        end
        for (int p = 0; p < `IP_MUX_S_COUNT; p++) begin
            ps = port_sel_t'(p);
            if (s_payload_tready[ps] && p != cur_port) begin
                fail_run($sformatf("payload ready raised on port %0d outside its frame", p));
            end
        end
        if (no_hdr_accept) begin
            check_ports("s_hdr_ready", s_hdr_ready, '0);
        end
        if (no_hdr_out) begin
            check_flag("m_hdr_valid", m_hdr_valid, 1'b0);
        end
        // a header waiting on m_hdr_ready must not move
        if (hdr_held) begin
            check_flag("m_hdr_valid", m_hdr_valid, 1'b1);
            check_hdr("m_hdr", m_hdr, hdr_prev);
        end
        hdr_held = m_hdr_valid && !m_hdr_ready;
        hdr_prev = m_hdr;
        if (m_hdr_valid && m_hdr_ready) begin
            if (exp_hdr_q.size() == 0) begin
                fail_run("output header appeared while none was expected");
            end
            check_hdr("m_hdr", m_hdr, exp_hdr_q.pop_front());
        end
        if (m_payload_tvalid && m_payload_tready) begin
            if (exp_beat_q.size() == 0) begin
                fail_run("output payload beat appeared while none was expected");
            end
            b = exp_beat_q.pop_front();
            check_beat(m_payload_tdata, m_payload_tlast, m_payload_tuser, b);
        end
        @(posedge clk);
        for (int p = 0; p < `IP_MUX_S_COUNT; p++) begin
            ps = port_sel_t'(p);
            if (hdr_take[ps]) begin
                s_hdr_valid[ps] <= 1'b0;
            end
            if (beat_take[ps]) begin
                void'(src_q[ps].pop_front());
                present_beat(ps);
            end
        end
        m_payload_tready <= rand_ready ? next_bit() : 1'b1;
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while ((exp_beat_q.size() != 0 || exp_hdr_q.size() != 0) && n < limit) begin
            step();
            n++;
        end
        if (exp_beat_q.size() != 0 || exp_hdr_q.size() != 0) begin
            fail_run("timeout waiting for the expected frames at the output");
        end
    endtask

    task automatic wait_sent(input port_sel_t port, input int left, input int limit);
        int n;
        n = 0;
        while (src_q[port].size() > left && n < limit) begin
            step();
            n++;
        end
        if (src_q[port].size() > left) begin
            fail_run($sformatf("timeout waiting for source %0d to send its payload", port));
        end
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_flag("m_hdr_valid", m_hdr_valid, 1'b0);
        check_flag("m_payload_tvalid", m_payload_tvalid, 1'b0);
        check_ports("s_hdr_ready", s_hdr_ready, '0);
        check_ports("s_payload_tready", s_payload_tready, '0);
        @(posedge clk);
    endtask

    task automatic test_each_port();
        for (int p = 0; p < `IP_MUX_S_COUNT; p++) begin
            select <= port_sel_t'(p);
            load_frame(port_sel_t'(p), 1 + int'(random_bits(4)));
            wait_drained(200);
        end
    endtask

    task automatic test_disabled();
        enable <= 1'b0;
        select <= 2'd2;
        load_frame(2'd2, 5);
        no_hdr_accept = 1'b1;
        no_hdr_out    = 1'b1;
        repeat (20) step();
        no_hdr_accept = 1'b0;
        no_hdr_out    = 1'b0;
        enable <= 1'b1;
        wait_drained(200);
    endtask

    // new select and a waiting header on port 3 while port 0 is mid frame
    task automatic test_select_locked();
        select <= 2'd0;
        load_frame(2'd0, 12);
        wait_sent(2'd0, 8, 100);
        load_frame(2'd3, 6);
        select <= 2'd3;
        wait_drained(300);
    endtask

    task automatic test_payload_backpressure();
        rand_ready = 1'b1;
        for (int p = 0; p < `IP_MUX_S_COUNT; p++) begin
            select <= port_sel_t'(p);
            load_frame(port_sel_t'(p), 4 + int'(random_bits(4)));
            wait_drained(500);
        end
        rand_ready = 1'b0;
    endtask

    task automatic test_hdr_backpressure();
        m_hdr_ready <= 1'b0;
        select <= 2'd1;
        load_frame(2'd1, 6);
        wait_sent(2'd1, 0, 100);
        load_frame(2'd1, 4);
        no_hdr_accept = 1'b1;
        repeat (12) step();
        no_hdr_accept = 1'b0;
        m_hdr_ready <= 1'b1;
        wait_drained(300);
    endtask

    initial begin
        rst              <= 1'b1;
        enable           <= 1'b1;
        select           <= '0;
        s_hdr_valid      <= '0;
        s_hdr            <= '0;
        s_payload_tdata  <= '0;
        s_payload_tvalid <= '0;
        s_payload_tlast  <= '0;
        s_payload_tuser  <= '0;
        m_hdr_ready      <= 1'b1;
        m_payload_tready <= 1'b1;
        rand_ready    = 1'b0;
        no_hdr_accept = 1'b0;
        no_hdr_out    = 1'b0;
        hdr_held      = 1'b0;
        hdr_prev      = '0;
        cur_port      = -1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_each_port();
        test_disabled();
        test_select_locked();
        test_payload_backpressure();
        test_hdr_backpressure();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hdl
hdl/ip_mux_pkg.sv
hdl/ip_payload_if.sv
hdl/ip_frame_ctrl.sv
hdl/ip_payload_mux.sv
hdl/ip_payload_skid.sv
hdl/ip_mux.sv
tb/tb_ip_mux.sv

// File: run.sh
#!/bin/sh
# compile and run the IP mux testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_ip_mux -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_ip_mux 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx '>>> PASS'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
